// File: hdl/frontend_pkg.sv
package frontend_pkg;

  // major opcodes sit in bits [31:26] of every instruction word
  localparam logic [5:0] OP_RTYPE      = 6'b000000;
  localparam logic [5:0] OP_ADDI       = 6'b001000;
  localparam logic [5:0] OP_LW         = 6'b100011;
  localparam logic [5:0] OP_SW         = 6'b101011;
  localparam logic [5:0] OP_BEQ        = 6'b000100;
  localparam logic [5:0] OP_J          = 6'b000010;
  localparam logic [5:0] OP_NOP_BUBBLE = 6'b111000; // what a flushed slot decodes as
  localparam logic [5:0] OP_HALT       = 6'b101101; // stops fetch for good

  // alu operation selects handed to execute
  localparam logic [3:0] ALU_ADD   = 4'd0; // address calc and addi
  localparam logic [3:0] ALU_SUB   = 4'd1; // beq compare
  localparam logic [3:0] ALU_RTYPE = 4'd2; // execute looks at funct

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // packed R-type view of a word with the immediate and jump index overlaying the low bits
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_t;

  // whole words stored by the IF/ID register in place of a fetched instruction
  localparam instr_t NOP_BUBBLE_WORD = instr_t'({OP_NOP_BUBBLE, 26'd0});
  localparam instr_t HALT_WORD       = instr_t'({OP_HALT, 26'd0});

  typedef struct packed {
    instr_t      instr;
    logic [31:0] pc_plus4;
    logic        valid;    // low for a bubble
  } if_id_t;

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       halt;
    logic       alu_src;   // second operand is the immediate
    logic       reg_dst;   // write rd rather than rt
    logic [3:0] alu_op;
  } ctrl_t;

  // the ID/EX boundary as execute sees it
  typedef struct packed {
    logic        valid;
    logic [31:0] pc_plus4;
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [31:0] imm16;       // already sign extended to the full word
    logic [31:0] jump_target;
    ctrl_t       ctrl;
  } decoded_t;

  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
  } axil_aw_t;

  typedef struct packed {
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] bresp;
    logic       bvalid;
  } axil_b_t;

endpackage

// File: hdl/instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  frontend_pkg::axil_aw_t        aw,
  output logic                          awready,
  input  frontend_pkg::axil_w_t         w,
  output logic                          wready,
  output frontend_pkg::axil_b_t         b,
  input  logic                          bready,
  input  logic [$clog2(IMEM_WORDS)-1:0] rd_addr,
  output frontend_pkg::instr_t          rd_data
);
  import frontend_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  logic [31:0]   mem [IMEM_WORDS];
  logic          live_q;     // goes high one cycle after reset so the ready lines start low
  logic          aw_taken_q; // address captured and waiting for data or commit
  logic          w_taken_q;  // data captured and waiting for address or commit
  logic          bvalid_q;
  logic [AW-1:0] waddr_q;
  logic [31:0]   wdata_q;
  logic [3:0]    wstrb_q;
  logic          aw_fire;
  logic          w_fire;
  logic          commit;

  // each channel is open until its half is taken, and both close while a response waits
  assign awready = live_q && !aw_taken_q && !bvalid_q;
  assign wready  = live_q && !w_taken_q && !bvalid_q;
  assign aw_fire = aw.awvalid && awready;
  assign w_fire  = w.wvalid && wready;
  assign commit  = aw_taken_q && w_taken_q; // both halves are in hand so the array is written now

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      live_q     <= 1'b0;
      aw_taken_q <= 1'b0;
      w_taken_q  <= 1'b0;
      bvalid_q   <= 1'b0;
    end
    else
    begin
      live_q <= 1'b1;
      if (aw_fire)
        aw_taken_q <= 1'b1;
      if (w_fire)
        w_taken_q <= 1'b1;
      if (commit)
      begin
        aw_taken_q <= 1'b0;
        w_taken_q  <= 1'b0;
        bvalid_q   <= 1'b1; // response goes out together with the array write
      end
      else if (bvalid_q && bready)
        bvalid_q <= 1'b0;
    end
  end

  // host addresses are bytes while the array is indexed by word
  always_ff @(posedge clk)
  begin
    if (aw_fire)
      waddr_q <= aw.awaddr[AW+1:2];
    if (w_fire)
    begin
      wdata_q <= w.wdata;
      wstrb_q <= w.wstrb;
    end
  end

  // only the enabled byte lanes change
  always_ff @(posedge clk)
  begin
    if (commit)
      for (int i = 0; i < 4; i++)
        if (wstrb_q[i])
          mem[waddr_q][8*i +: 8] <= wdata_q[8*i +: 8];
  end

  assign b.bresp  = AXI_RESP_OKAY; // every write lands so the response is always OKAY
  assign b.bvalid = bvalid_q;

  assign rd_data = instr_t'(mem[rd_addr]); // asynchronous so fetch sees the word the same cycle

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          run,
  input  logic                          stall,
  input  logic                          redirect_valid,
  input  logic [31:0]                   redirect_pc,
  input  logic                          jump_valid,
  input  logic [31:0]                   jump_target,
  input  logic                          halt_seen,
  output logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  frontend_pkg::instr_t          imem_data,
  output frontend_pkg::if_id_t          fetch_out,
  output logic                          if_flush,
  output logic                          halted
);
  import frontend_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  logic [AW-1:0] pc_q;     // word index that gives the byte PC when shifted left by two
  logic [AW-1:0] pc_inc;
  logic [AW-1:0] pc_d;
  logic          halt_now; // halted already or the halt is being issued this cycle
  logic          hold;

  assign pc_inc   = pc_q + 1'b1;                    // rolls over at the memory depth
  assign halt_now = halted || halt_seen;
  assign hold     = stall || halt_now || !run;
  assign if_flush = redirect_valid || jump_valid;   // wrong-path word in IF gets dropped

  // a redirect from execute outranks a jump resolved in decode
  always_comb
  begin
    if (redirect_valid)
      pc_d = redirect_pc[AW+1:2];
    else if (jump_valid)
      pc_d = jump_target[AW+1:2];
    else if (hold)
      pc_d = pc_q;
    else
      pc_d = pc_inc;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc_q   <= '0;
      halted <= 1'b0;
    end
    else
    begin
      pc_q   <= pc_d;
      halted <= halted || halt_seen; // sticky until the next reset
    end
  end

  assign imem_addr          = pc_q;
  assign fetch_out.instr    = imem_data;
  assign fetch_out.pc_plus4 = 32'({pc_inc, 2'b00});
  assign fetch_out.valid    = run && !halt_now; // nothing fetched counts once a halt is issued

endmodule

// File: hdl/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
  input  logic                 clk,
  input  logic                 arst_n,
  input  frontend_pkg::if_id_t fetch_in,
  input  logic                 stall,
  input  logic                 if_flush,
  input  logic                 halted,
  output frontend_pkg::if_id_t if_id_out
);
  import frontend_pkg::*;

  if_id_t slot_q;

  // priority is halt, then flush, then stall, then a normal load
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot_q.instr    <= NOP_BUBBLE_WORD; // comes up as an empty slot
      slot_q.pc_plus4 <= '0;
      slot_q.valid    <= 1'b0;
    end
    else if (halted)
    begin
      // keep presenting the halt word, but never as a live instruction again
      slot_q.instr    <= HALT_WORD;
      slot_q.pc_plus4 <= fetch_in.pc_plus4;
      slot_q.valid    <= 1'b0;
    end
    else if (if_flush)
    begin
      slot_q.instr    <= NOP_BUBBLE_WORD;    // wrong-path word replaced by a bubble
      slot_q.pc_plus4 <= fetch_in.pc_plus4;  // pc+4 still tracks fetch on a flush
      slot_q.valid    <= 1'b0;
    end
    else if (!stall)
    begin
      slot_q <= fetch_in;
    end
    // a stall leaves the whole slot as it is, pc+4 included
  end

  assign if_id_out = slot_q;

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  frontend_pkg::if_id_t   if_id_in,
  input  logic                   redirect_valid,
  output frontend_pkg::decoded_t dec_out,
  output logic                   stall,
  output logic                   jump_valid,
  output logic [31:0]            jump_target,
  output logic                   halt_seen
);
  import frontend_pkg::*;

  instr_t      ins;
  logic [31:0] raw;       // same word as a flat vector for the immediate and jump index
  logic        reads_rs;
  logic        reads_rt;
  logic        issue;     // the IF/ID instruction moves on to execute at this edge
  ctrl_t       ctrl_d;
  decoded_t    dec_d;
  decoded_t    dec_q;     // payload half of the ID/EX register
  logic        valid_q;
  ctrl_t       ctrl_q;

  assign ins = if_id_in.instr;
  assign raw = if_id_in.instr;

  // pseudo-direct target built from the upper pc bits and the 26-bit index
  assign jump_target = {if_id_in.pc_plus4[31:28], raw[25:0], 2'b00};

  // control table, which also says which source registers get read
  always_comb
  begin
    ctrl_d   = '0;
    reads_rs = 1'b0;
    reads_rt = 1'b0;
    case (ins.opcode)
      OP_RTYPE:
      begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.reg_dst   = 1'b1;
        ctrl_d.alu_op    = ALU_RTYPE;
        reads_rs         = 1'b1;
        reads_rt         = 1'b1;
      end
      OP_ADDI:
      begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.alu_src   = 1'b1;
        ctrl_d.alu_op    = ALU_ADD;
        reads_rs         = 1'b1;
      end
      OP_LW:
      begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.mem_read  = 1'b1;
        ctrl_d.alu_src   = 1'b1;
        ctrl_d.alu_op    = ALU_ADD;
        reads_rs         = 1'b1; // base only since rt is the destination
      end
      OP_SW:
      begin
        ctrl_d.mem_write = 1'b1;
        ctrl_d.alu_src   = 1'b1;
        ctrl_d.alu_op    = ALU_ADD;
        reads_rs         = 1'b1;
        reads_rt         = 1'b1; // store data
      end
      OP_BEQ:
      begin
        ctrl_d.branch = 1'b1;
        ctrl_d.alu_op = ALU_SUB;
        reads_rs      = 1'b1;
        reads_rt      = 1'b1;
      end
      OP_J:    ctrl_d.jump = 1'b1;
      OP_HALT: ctrl_d.halt = 1'b1;
      default: ctrl_d = '0; // bubble opcode and anything unknown do nothing
    endcase
  end

  // the lw now in ID/EX has no data yet for a reader of its rt sitting in IF/ID
  assign stall = if_id_in.valid && dec_out.valid && dec_out.ctrl.mem_read &&
                 ((reads_rs && (ins.rs == dec_out.rt)) ||
                  (reads_rt && (ins.rt == dec_out.rt)));

  assign issue      = if_id_in.valid && !redirect_valid && !stall;
  assign jump_valid = issue && (ins.opcode == OP_J);
  assign halt_seen  = issue && (ins.opcode == OP_HALT); // fires once and fetch turns it sticky

  always_comb
  begin
    dec_d.valid       = issue;
    dec_d.pc_plus4    = if_id_in.pc_plus4;
    dec_d.opcode      = ins.opcode;
    dec_d.rs          = ins.rs;
    dec_d.rt          = ins.rt;
    dec_d.rd          = ins.rd;
    dec_d.shamt       = ins.shamt;
    dec_d.funct       = ins.funct;
    dec_d.imm16       = {{16{raw[15]}}, raw[15:0]};
    dec_d.jump_target = jump_target;
    dec_d.ctrl        = ctrl_d;
  end

  // valid and control are what execute acts on and a bubble zeroes them
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end
    else
    begin
      valid_q <= issue;
      ctrl_q  <= issue ? ctrl_d : '0;
    end
  end

  always_ff @(posedge clk)
  begin
    dec_q <= dec_d;
  end

  always_comb
  begin
    dec_out       = dec_q;
    dec_out.valid = valid_q;
    dec_out.ctrl  = ctrl_q;
  end

endmodule

// File: hdl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  frontend_pkg::axil_aw_t aw,
  output logic                   awready,
  input  frontend_pkg::axil_w_t  w,
  output logic                   wready,
  output frontend_pkg::axil_b_t  b,
  input  logic                   bready,
  input  logic                   redirect_valid,
  input  logic [31:0]            redirect_pc,
  output frontend_pkg::decoded_t dec_out,
  output logic                   halted
);
  import frontend_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  logic [AW-1:0] imem_addr;
  instr_t        imem_data;
  if_id_t        fetch_out;   // IF stage before the register
  if_id_t        if_id;       // registered IF/ID slot seen by decode
  logic          if_flush;
  logic          stall;
  logic          jump_valid;
  logic [31:0]   jump_target;
  logic          halt_seen;

  // program store that the host loads before run
  instr_mem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) u_instr_mem (
    .clk     (clk),
    .arst_n  (arst_n),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .rd_addr (imem_addr),
    .rd_data (imem_data)
  );

  fetch_unit #(
    .IMEM_WORDS(IMEM_WORDS)
  ) u_fetch_unit (
    .clk            (clk),
    .arst_n         (arst_n),
    .run            (run),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .jump_valid     (jump_valid),
    .jump_target    (jump_target),
    .halt_seen      (halt_seen),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .fetch_out      (fetch_out),
    .if_flush       (if_flush),
    .halted         (halted)
  );

  if_id_reg u_if_id_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch_in  (fetch_out),
    .stall     (stall),
    .if_flush  (if_flush),
    .halted    (halted),
    .if_id_out (if_id)
  );

  // decode feeds jumps, stalls and the halt back to fetch
  decode_unit u_decode_unit (
    .clk            (clk),
    .arst_n         (arst_n),
    .if_id_in       (if_id),
    .redirect_valid (redirect_valid),
    .dec_out        (dec_out),
    .stall          (stall),
    .jump_valid     (jump_valid),
    .jump_target    (jump_target),
    .halt_seen      (halt_seen)
  );

endmodule

// File: testbench/frontend_asserts.sv
`timescale 1ns/1ps

module frontend_asserts (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   halted,
  input frontend_pkg::axil_b_t  b,
  input logic                   bready,
  input logic                   redirect_valid,
  input frontend_pkg::decoded_t dec_out
);

  int fail_count = 0; // failed assertions so far

  // once a halt is issued only reset brings fetch back
  halted_sticky: assert property (
    @(posedge clk) disable iff (!arst_n) halted |=> halted
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("halted fell while out of reset");
  end

  // a write response stays up until the host takes it
  bvalid_held: assert property (
    @(posedge clk) disable iff (!arst_n) (b.bvalid && !bready) |=> b.bvalid
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("bvalid dropped before bready");
  end

  // the instruction in IF/ID is killed by a redirect, so execute sees a bubble next
  redirect_kills: assert property (
    @(posedge clk) disable iff (!arst_n) redirect_valid |=> !dec_out.valid
  )
  else
  begin
    fail_count = fail_count + 1;
    $error("decode issued a valid instruction right after a redirect");
  end

endmodule

bind frontend_top frontend_asserts u_asserts (
  .clk            (clk),
  .arst_n         (arst_n),
  .halted         (halted),
  .b              (b),
  .bready         (bready),
  .redirect_valid (redirect_valid),
  .dec_out        (dec_out)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk    = 1'b0;
    arst_n = 1'b0;                   // in reset from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;                // released just after an edge and clear of the flops
  end

  always #2 clk = ~clk;              // 4 ns period

endmodule

// File: testbench/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;
  import frontend_pkg::*;

  localparam int IMEM_WORDS   = 256;
  localparam int PROG_LEN     = 40;
  localparam int HALT_IDX     = PROG_LEN - 1;               // last word is always the halt
  localparam int LOAD_CYCLES  = 10 * PROG_LEN;              // split writes and slow bready included
  localparam int TIMEOUT      = 4 * (PROG_LEN + LOAD_CYCLES) + 100;
  localparam int QUIET_CYCLES = 20;

  logic        clk;
  logic        arst_n;
  logic        run;
  axil_aw_t    aw;
  logic        awready;
  axil_w_t     w;
  logic        wready;
  axil_b_t     b;
  logic        bready;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  decoded_t    dec_out;
  logic        halted;

  logic [31:0] prog [PROG_LEN];     // the program as the host loads it with one entry per word
  logic [31:0] rng_state = 32'h7629;
  int          cycle_count = 0;

  tb_clock_gen #(
    .RESET_CYCLES(5)
  ) u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  frontend_top #(
    .IMEM_WORDS(IMEM_WORDS)
  ) UUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .run            (run),
    .aw             (aw),
    .awready        (awready),
    .w              (w),
    .wready         (wready),
    .b              (b),
    .bready         (bready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .dec_out        (dec_out),
    .halted         (halted)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223; // plain 32-bit LCG
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:8] % n);  // low LCG bits cycle too fast to use
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_decoded(input decoded_t got, input decoded_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error %0t: decode of pc+4 %h got %h expected %h",
                              $time, exp.pc_plus4, got, exp));
  endtask

  task automatic check_bresp(input axil_b_t got, input axil_b_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error %0t: write response got %h expected %h",
                              $time, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("error %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // source registers an instruction reads according to the MIPS formats
  function automatic logic reads_reg(input logic [31:0] word, input logic [4:0] r);
    case (word[31:26])
      OP_RTYPE, OP_SW, OP_BEQ: return (word[25:21] == r) || (word[20:16] == r);
      OP_ADDI, OP_LW:          return word[25:21] == r;
      default:                 return 1'b0;
    endcase
  endfunction

  // what execute should receive for the word at index idx
  function automatic decoded_t expect_decoded(input logic [31:0] word, input int idx);
    decoded_t    e;
    logic [31:0] pc4;
    pc4           = 32'(4 * (idx + 1));
    e             = '0;
    e.valid       = 1'b1;
    e.pc_plus4    = pc4;
    e.opcode      = word[31:26];
    e.rs          = word[25:21];
    e.rt          = word[20:16];
    e.rd          = word[15:11];
    e.shamt       = word[10:6];
    e.funct       = word[5:0];
    e.imm16       = {{16{word[15]}}, word[15:0]};
    e.jump_target = {pc4[31:28], word[25:0], 2'b00};
    case (word[31:26])
      OP_RTYPE:
      begin
        e.ctrl.reg_write = 1'b1;
        e.ctrl.reg_dst   = 1'b1;
        e.ctrl.alu_op    = ALU_RTYPE;
      end
      OP_ADDI:
      begin
        e.ctrl.reg_write = 1'b1;
        e.ctrl.alu_src   = 1'b1;
        e.ctrl.alu_op    = ALU_ADD;
      end
      OP_LW:
      begin
        e.ctrl.reg_write = 1'b1;
        e.ctrl.mem_read  = 1'b1;
        e.ctrl.alu_src   = 1'b1;
        e.ctrl.alu_op    = ALU_ADD;
      end
      OP_SW:
      begin
        e.ctrl.mem_write = 1'b1;
        e.ctrl.alu_src   = 1'b1;
        e.ctrl.alu_op    = ALU_ADD;
      end
      OP_BEQ:
      begin
        e.ctrl.branch = 1'b1;
        e.ctrl.alu_op = ALU_SUB;
      end
      OP_J:     e.ctrl.jump = 1'b1;
      OP_HALT:  e.ctrl.halt = 1'b1;
      default:  e.ctrl = '0;
    endcase
    return e;
  endfunction

  // random program whose branches and jumps only go forward and never past the halt
  task automatic build_program();
    int          kind;
    int          span;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] r;
    for (int i = 0; i < HALT_IDX; i++)
    begin
      kind = rand_below(8);
      rs   = 5'(rand_below(4));   // few registers, so load-use pairs come up often
      rt   = 5'(rand_below(4));
      rd   = 5'(rand_below(32));
      r    = next_rand();
      span = HALT_IDX - i - 1;    // words between the one after this and the halt
      if (kind >= 6 && span < 1)
        kind = 0;
      case (kind)
        0, 1:    prog[i] = {OP_RTYPE, rs, rt, rd, r[10:6], r[5:0]};
        2:       prog[i] = {OP_ADDI, rs, rt, r[15:0]};
        3, 4:    prog[i] = {OP_LW, rs, rt, r[15:0]};
        5:       prog[i] = {OP_SW, rs, rt, r[15:0]};
        6:       prog[i] = {OP_BEQ, rs, rt, 16'(1 + rand_below(span < 3 ? span : 3))};
        default: prog[i] = {OP_J, 26'(i + 2 + rand_below(span < 3 ? span : 3))};
      endcase
    end
    r              = next_rand();
    prog[HALT_IDX] = {OP_HALT, r[25:0]};
  endtask

  // one AXI4-Lite write where ready is sampled mid-cycle and the handshake lands on the next edge
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic    aw_hs;
    logic    w_hs;
    axil_b_t okay;
    okay.bresp  = AXI_RESP_OKAY;
    okay.bvalid = 1'b1;
    aw.awaddr   = addr;
    aw.awvalid  = 1'b1;
    w.wdata     = data;
    w.wstrb     = strb;
    w.wvalid    = 1'b1;
    while (aw.awvalid || w.wvalid)
    begin
      aw_hs = aw.awvalid && awready;
      w_hs  = w.wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_hs)
        aw.awvalid = 1'b0;
      if (w_hs)
        w.wvalid = 1'b0;
    end
    while (!b.bvalid)
    begin
      @(posedge clk);
      #1;
    end
    check_bresp(b, okay);
    repeat (rand_below(3)) // a slow host makes the response wait
    begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    @(posedge clk);       // response retires at this edge
    #1;
    bready = 1'b0;
  endtask

  // every third word goes in as two half writes whose other lanes carry junk
  task automatic load_program();
    logic [31:0] junk;
    for (int i = 0; i < PROG_LEN; i++)
    begin
      if (i % 3 == 0)
      begin
        junk = next_rand();
        axi_write(32'(4 * i), {junk[31:16], prog[i][15:0]}, 4'b0011);
        axi_write(32'(4 * i), {prog[i][31:16], junk[15:0]}, 4'b1100);
      end
      else
        axi_write(32'(4 * i), prog[i], 4'b1111);
    end
  endtask

  // walk the program by pc and hold the pipeline to the exact bubble count after each issue
  task automatic run_program();
    int          idx;
    int          bubbles;
    int          gap_exp;
    logic        done;
    logic        take;
    logic [31:0] word;
    logic [31:0] pc4;
    idx     = 0;
    bubbles = 0;
    gap_exp = 1;         // run to first issue is fetch plus the IF/ID stage
    done    = 1'b0;
    run     = 1'b1;
    while (!done)
    begin
      @(posedge clk);
      #1;
      take = 1'b0;
      if (dec_out.valid)
      begin
        if (bubbles != gap_exp)
          stop_on_error($sformatf("error %0t: an instruction issued after %0d bubbles, not %0d",
                                  $time, bubbles, gap_exp));
        word    = prog[idx];
        pc4     = 32'(4 * (idx + 1));
        bubbles = 0;
        check_decoded(dec_out, expect_decoded(word, idx));
        check_flag("halted", halted, word[31:26] == OP_HALT); // halted rises with the halt itself
        case (word[31:26])
          OP_J:
          begin
            idx     = int'(word[25:0]); // upper pc bits are zero in this small program
            gap_exp = 1;
          end
          OP_BEQ:
          begin
            take = (rand_below(2) == 1);
            if (take)
            begin
              redirect_pc = pc4 + {{14{word[15]}}, word[15:0], 2'b00};
              idx         = idx + 1 + int'($signed(word[15:0]));
              gap_exp     = 2;    // IF/ID and the fetched word are both wrong path
            end
            else
            begin
              idx     = idx + 1;
              gap_exp = 0;
            end
          end
          OP_LW:
          begin
            gap_exp = reads_reg(prog[idx + 1], word[20:16]) ? 1 : 0; // load-use costs a cycle
            idx     = idx + 1;
          end
          OP_HALT: done = 1'b1;
          default:
          begin
            idx     = idx + 1;
            gap_exp = 0;
          end
        endcase
      end
      else
      begin
        bubbles = bubbles + 1;
        if (bubbles > gap_exp)
          stop_on_error($sformatf("error %0t: decode went %0d cycles without an instruction",
                                  $time, bubbles));
      end
      redirect_valid = take; // held for one cycle and dropped on the next pass
    end
  endtask

  // after the halt nothing else may leave decode
  task automatic expect_quiet();
    repeat (QUIET_CYCLES)
    begin
      @(posedge clk);
      #1;
      redirect_valid = 1'b0;
      if (dec_out.valid)
        stop_on_error($sformatf("error %0t: a valid instruction left decode after the halt",
                                $time));
      check_flag("halted", halted, 1'b1);
    end
  endtask

  initial
  begin
    run            = 1'b0;
    aw             = '0;
    w              = '0;
    bready         = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    build_program();
    wait (arst_n === 1'b1);
    #1;
    // reset leaves the write channel closed and nothing in flight
    check_flag("awready", awready, 1'b0);
    check_flag("wready", wready, 1'b0);
    check_flag("bvalid", b.bvalid, 1'b0);
    check_flag("dec_out.valid", dec_out.valid, 1'b0);
    check_flag("halted", halted, 1'b0);
    @(posedge clk);
    #1;
    load_program();
    run_program();
    expect_quiet();
    if (UUT.u_asserts.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures were reported", UUT.u_asserts.fail_count);
      $display("Test FAILED");
      $fatal(1, "assertions failed during the run");
    end
  end

  // the first failed assertion in the bound checker ends the run
  always @(UUT.u_asserts.fail_count)
  begin
    if (UUT.u_asserts.fail_count != 0)
      stop_on_error("a bound assertion failed, its message is printed above");
  end

  // limit covers reset, the whole load and every instruction at its worst spacing
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TIMEOUT)
      stop_on_error($sformatf("the pipeline never halted within %0d cycles", TIMEOUT));
  end

endmodule

// File: compile.f
hdl/frontend_pkg.sv
hdl/instr_mem.sv
hdl/fetch_unit.sv
hdl/if_id_reg.sv
hdl/decode_unit.sv
hdl/frontend_top.sv
testbench/frontend_asserts.sv
testbench/tb_clock_gen.sv
testbench/frontend_tb.sv
